//--- sources.f
src/soc_io_pkg.sv
src/reg_bus_if.sv
src/pad_seq_if.sv
src/axil_slave_port.sv
src/pad_sequencer.sv
src/pad_reader.sv
src/scratch_ram.sv
src/io_register_map.sv
src/soc_io_top.sv
tests/tb_clock_gen.sv
tests/tb_soc_io_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_soc_io_top \
	-f sources.f -o tb_soc_io_top > build.log 2>&1 \
	&& ./obj_dir/tb_soc_io_top > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log

grep -qF '*** TEST PASSED ***' sim.log \
	&& echo "Simulation result: pass" \
	|| { echo "Simulation result: fail"; exit 1; }

//--- tests/tb_soc_io_top.sv
// Table-driven testbench for soc_io_top with an AXI-Lite driver, game pad models and a timeout
`timescale 1ns/10ps

module pad_model (
	input logic clk_50mhz,
	input logic pad_latch,
	input logic pad_clock,
	input soc_io_pkg::pad_buttons_t buttons,
	output logic pad_data
);

	logic latch_prev;
	logic clock_prev;
	soc_io_pkg::pad_buttons_t shift_byte;
	int bit_pos;

	initial begin
		pad_data = 1'b1;
		latch_prev = 1'b0;
		clock_prev = 1'b1;
		shift_byte = '0;
		bit_pos = 8;
	end

	// Bit k goes out after k rising pad clock edges, low means pressed
	always @(negedge clk_50mhz) begin
		if (pad_latch && !latch_prev) begin
			shift_byte = buttons;
			bit_pos = 0;
		end else if (pad_clock && !clock_prev && bit_pos < 8) begin
			bit_pos = bit_pos + 1;
		end
		latch_prev = pad_latch;
		clock_prev = pad_clock;
		pad_data = (bit_pos < 8) ? ~shift_byte[bit_pos[2:0]] : 1'b1;
	end

endmodule

module tb_soc_io_top;

	typedef enum logic [1:0] {op_write, op_read, op_pads, op_cycles} op_t;

	typedef struct packed {
		op_t op;
		soc_io_pkg::bus_addr_t addr;
		soc_io_pkg::bus_data_t wdata;
		soc_io_pkg::bus_strb_t strb;
		soc_io_pkg::bus_data_t exp_data;
		soc_io_pkg::bus_resp_t exp_resp;
		int hold;
	} test_entry_t;

	logic clk_50mhz;
	logic resetn;
	soc_io_pkg::bus_addr_t awaddr;
	soc_io_pkg::bus_addr_t araddr;
	soc_io_pkg::bus_data_t wdata;
	soc_io_pkg::bus_data_t rdata;
	soc_io_pkg::bus_strb_t wstrb;
	soc_io_pkg::bus_resp_t bresp;
	soc_io_pkg::bus_resp_t rresp;
	logic awvalid;
	logic awready;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic rready;
	logic pad_latch;
	logic pad_clock;
	logic pad_data_0;
	logic pad_data_1;
	soc_io_pkg::pad_buttons_t pad_bytes [soc_io_pkg::PAD_COUNT];

	test_entry_t tests [$];
	soc_io_pkg::bus_data_t ram_model [soc_io_pkg::RAM_WORDS];
	integer seed;
	int error_count;
	int check_count;
	int cycle_count;
	int cycle_limit;

	tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) tb_clock_gen_inst (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn)
	);

	soc_io_top soc_io_top_inst (
		.clk_50mhz(clk_50mhz), .resetn(resetn),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.pad_latch(pad_latch), .pad_clock(pad_clock), .pad_data({pad_data_1, pad_data_0})
	);

	pad_model pad_model_0 (.clk_50mhz(clk_50mhz), .pad_latch(pad_latch),
		.pad_clock(pad_clock), .buttons(pad_bytes[0]), .pad_data(pad_data_0));
	pad_model pad_model_1 (.clk_50mhz(clk_50mhz), .pad_latch(pad_latch),
		.pad_clock(pad_clock), .buttons(pad_bytes[1]), .pad_data(pad_data_1));

	always @(posedge clk_50mhz) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the DUT did not finish the tests within %0d cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, actual, expected);
			error_count++;
		end
	endtask

	task automatic add_test(input op_t op, input logic [11:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [31:0] exp_data, input logic [1:0] exp_resp,
		input int hold);
		test_entry_t entry;
		entry = '{op, addr, data, strb, exp_data, exp_resp, hold};
		tests.push_back(entry);
	endtask

	function automatic logic in_ram(input soc_io_pkg::bus_addr_t addr);
		return addr >= soc_io_pkg::RAM_BASE_OFFSET &&
			addr < soc_io_pkg::RAM_BASE_OFFSET + soc_io_pkg::RAM_WORDS * 4;
	endfunction

	// Alternate a pending read and a pending write on successive cycles
	task automatic offer_request(input int k);
		arvalid = (k % 2 == 0);
		awvalid = (k % 2 != 0);
		wvalid = (k % 2 != 0);
	endtask

	task automatic withdraw_requests();
		arvalid = 1'b0;
		awvalid = 1'b0;
		wvalid = 1'b0;
	endtask

	task automatic bus_read(input soc_io_pkg::bus_addr_t addr, input int hold,
		output soc_io_pkg::bus_data_t data, output soc_io_pkg::bus_resp_t resp);
		soc_io_pkg::bus_data_t held;
		@(negedge clk_50mhz);
		araddr = addr;
		arvalid = 1'b1;
		#1;
		while (!arready) begin
			@(negedge clk_50mhz);
			#1;
		end
		@(negedge clk_50mhz);
		arvalid = 1'b0;
		while (!rvalid) @(negedge clk_50mhz);
		held = rdata;
		// Response must wait while the manager holds rready low, new requests stay refused
		for (int k = 0; k < hold; k++) begin
			offer_request(k);
			#1;
			check_value("arready under back-pressure", arready, 0);
			check_value("awready under back-pressure", awready, 0);
			@(negedge clk_50mhz);
			check_value("rvalid under back-pressure", rvalid, 1);
			check_value("rdata under back-pressure", rdata, held);
		end
		withdraw_requests();
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		@(negedge clk_50mhz);
		rready = 1'b0;
		check_value("rvalid after transfer", rvalid, 0);
	endtask

	task automatic bus_write(input soc_io_pkg::bus_addr_t addr, input soc_io_pkg::bus_data_t data,
		input soc_io_pkg::bus_strb_t strb, input int hold, output soc_io_pkg::bus_resp_t resp);
		@(negedge clk_50mhz);
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		#1;
		while (!awready) begin
			@(negedge clk_50mhz);
			#1;
		end
		check_value("wready with awready", wready, 1);
		@(negedge clk_50mhz);
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid) @(negedge clk_50mhz);
		for (int k = 0; k < hold; k++) begin
			offer_request(k);
			#1;
			check_value("awready under back-pressure", awready, 0);
			check_value("arready under back-pressure", arready, 0);
			@(negedge clk_50mhz);
			check_value("bvalid under back-pressure", bvalid, 1);
		end
		withdraw_requests();
		resp = bresp;
		bready = 1'b1;
		@(negedge clk_50mhz);
		bready = 1'b0;
		check_value("bvalid after transfer", bvalid, 0);
	endtask

	task automatic run_test(input test_entry_t t);
		soc_io_pkg::bus_data_t data;
		soc_io_pkg::bus_data_t first;
		soc_io_pkg::bus_resp_t resp;
		soc_io_pkg::bus_addr_t offset;
		logic [31:0] rnd;
		offset = t.addr - soc_io_pkg::RAM_BASE_OFFSET;
		case (t.op)
			op_write: begin
				bus_write(t.addr, t.wdata, t.strb, t.hold, resp);
				check_value("bresp", resp, t.exp_resp);
				if (in_ram(t.addr) && t.exp_resp == soc_io_pkg::RESP_OKAY) begin
					for (int lane = 0; lane < 4; lane++) begin
						if (t.strb[lane]) begin
							ram_model[offset[7:2]][lane * 8 +: 8] = t.wdata[lane * 8 +: 8];
						end
					end
				end
			end
			op_read: begin
				bus_read(t.addr, t.hold, data, resp);
				check_value("rresp", resp, t.exp_resp);
				check_value("rdata", data, in_ram(t.addr) ? ram_model[offset[7:2]] : t.exp_data);
			end
			op_pads: begin
				for (int p = 0; p < soc_io_pkg::PAD_COUNT; p++) begin
					rnd = $random(seed);
					pad_bytes[p] = rnd[7:0];
				end
				// The second latch starts only after a frame with the new bytes was published
				repeat (2) @(posedge pad_latch);
				bus_read(t.addr, t.hold, data, resp);
				check_value("pads rresp", resp, t.exp_resp);
				check_value("pads rdata", data, {16'h0000, pad_bytes[1], pad_bytes[0]});
			end
			default: begin
				bus_read(t.addr, 0, first, resp);
				check_value("first cycles rresp", resp, t.exp_resp);
				repeat (t.wdata) @(negedge clk_50mhz);
				bus_read(t.addr, t.hold, data, resp);
				check_value("second cycles rresp", resp, t.exp_resp);
				check_value("cycle counter increased", data > first, 1);
				check_value("cycle counter distance", data - first >= t.wdata, 1);
			end
		endcase
	endtask

	initial begin
		int errors_before;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		pad_bytes[0] = '0;
		pad_bytes[1] = '0;
		seed = 32'ha488_00e5;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;

		add_test(op_read, 12'h000, 0, 0, soc_io_pkg::SOC_IO_ID, soc_io_pkg::RESP_OKAY, 0);
		add_test(op_write, 12'h100, 32'h1122_3344, 4'hF, 0, soc_io_pkg::RESP_OKAY, 0);
		add_test(op_write, 12'h104, 32'hAABB_CCDD, 4'hF, 0, soc_io_pkg::RESP_OKAY, 0);
		add_test(op_write, 12'h1FC, 32'h0F0E_0D0C, 4'hF, 0, soc_io_pkg::RESP_OKAY, 0);
		add_test(op_write, 12'h100, 32'h5566_7788, 4'h5, 0, soc_io_pkg::RESP_OKAY, 2);
		add_test(op_write, 12'h104, 32'h9900_0000, 4'h8, 0, soc_io_pkg::RESP_OKAY, 0);
		add_test(op_write, 12'h1FC, 32'h0000_EE00, 4'h6, 0, soc_io_pkg::RESP_OKAY, 0);
		add_test(op_read, 12'h100, 0, 0, 0, soc_io_pkg::RESP_OKAY, 3);
		add_test(op_read, 12'h104, 0, 0, 0, soc_io_pkg::RESP_OKAY, 0);
		add_test(op_read, 12'h1FC, 0, 0, 0, soc_io_pkg::RESP_OKAY, 2);
		add_test(op_write, 12'h000, 32'hDEAD_BEEF, 4'hF, 0, soc_io_pkg::RESP_SLVERR, 3);
		add_test(op_read, 12'h00C, 0, 0, 0, soc_io_pkg::RESP_SLVERR, 0);
		add_test(op_write, 12'h00C, 32'h1234_5678, 4'hF, 0, soc_io_pkg::RESP_SLVERR, 0);
		add_test(op_read, 12'h200, 0, 0, 0, soc_io_pkg::RESP_SLVERR, 1);
		add_test(op_write, 12'h004, 32'h0000_0001, 4'h1, 0, soc_io_pkg::RESP_SLVERR, 0);
		add_test(op_pads, 12'h008, 0, 0, 0, soc_io_pkg::RESP_OKAY, 0);
		add_test(op_cycles, 12'h004, 40, 0, 0, soc_io_pkg::RESP_OKAY, 0);
		add_test(op_read, 12'h000, 0, 0, soc_io_pkg::SOC_IO_ID, soc_io_pkg::RESP_OKAY, 4);
		cycle_limit = tests.size() * 50 + 16 +
			4 * soc_io_pkg::PAD_FRAME_TICKS * soc_io_pkg::PAD_TICK_CYCLES;

		@(posedge resetn);
		// Pad pins and response valids come out of reset idle
		check_value("pad_latch after reset", pad_latch, 0);
		check_value("pad_clock after reset", pad_clock, 1);
		check_value("rvalid after reset", rvalid, 0);
		check_value("bvalid after reset", bvalid, 0);
		foreach (tests[i]) begin
			errors_before = error_count;
			run_test(tests[i]);
			$display("test %0d %s at 0x%03h: %s", i, tests[i].op.name(), tests[i].addr,
				(error_count == errors_before) ? "ok" : "mismatch");
		end
		$display("%0d tests, %0d checks, %0d errors", tests.size(), check_count, error_count);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- tests/tb_clock_gen.sv
// Testbench clock and synchronous active-low reset source, instantiated once by the testbench top
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic clk_50mhz,
	output logic resetn
);

	initial begin
		clk_50mhz = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk_50mhz = ~clk_50mhz;
		end
	end

	// Released on a falling edge like the rest of the stimulus
	initial begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_50mhz);
		@(negedge clk_50mhz);
		resetn = 1'b1;
	end

endmodule

//--- src/soc_io_top.sv
// Top level of the memory-mapped I/O block with the AXI-Lite port and the game pad pins
`timescale 1ns/10ps

module soc_io_top (
	input logic clk_50mhz,
	input logic resetn,

	input soc_io_pkg::bus_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input soc_io_pkg::bus_data_t wdata,
	input soc_io_pkg::bus_strb_t wstrb,
	input logic wvalid,
	output logic wready,
	output soc_io_pkg::bus_resp_t bresp,
	output logic bvalid,
	input logic bready,
	input soc_io_pkg::bus_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output soc_io_pkg::bus_data_t rdata,
	output soc_io_pkg::bus_resp_t rresp,
	output logic rvalid,
	input logic rready,

	output logic pad_latch,
	output logic pad_clock,
	input logic [soc_io_pkg::PAD_COUNT-1:0] pad_data
);

	reg_bus_if reg_bus ();
	pad_seq_if pad_seq ();

	soc_io_pkg::pad_buttons_t pad_buttons [soc_io_pkg::PAD_COUNT];

	axil_slave_port axil_slave_port_inst (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.bus(reg_bus)
	);

	pad_sequencer pad_sequencer_inst (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.seq(pad_seq)
	);

	// Latch and clock are shared by all pads
	assign pad_latch = pad_seq.latch;
	assign pad_clock = pad_seq.clock;

	for (genvar i = 0; i < soc_io_pkg::PAD_COUNT; i++) begin : g_pad
		pad_reader pad_reader_inst (
			.clk_50mhz(clk_50mhz),
			.resetn(resetn),
			.seq(pad_seq),
			.pad_data(pad_data[i]),
			.buttons(pad_buttons[i])
		);
	end

	io_register_map io_register_map_inst (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.bus(reg_bus),
		.pad_buttons(pad_buttons)
	);

endmodule

//--- src/io_register_map.sv
// Decodes register bus accesses into the ID, cycle counter, pad and scratch RAM registers
`timescale 1ns/10ps

module io_register_map (
	input logic clk_50mhz,
	input logic resetn,
	reg_bus_if.target bus,
	input soc_io_pkg::pad_buttons_t pad_buttons [soc_io_pkg::PAD_COUNT]
);

	logic start;
	logic in_ram;
	logic reg_err;
	logic ack_q;
	logic err_q;
	logic ram_sel_q;
	soc_io_pkg::bus_addr_t ram_offset;
	soc_io_pkg::bus_strb_t ram_we;
	soc_io_pkg::bus_data_t ram_rdata;
	soc_io_pkg::bus_data_t pads_word;
	soc_io_pkg::bus_data_t reg_rdata;
	soc_io_pkg::bus_data_t rdata_q;
	soc_io_pkg::bus_data_t cycle_count;

	// req stays up during the ack cycle
	assign start = bus.req && !ack_q;

	assign ram_offset = bus.addr - soc_io_pkg::RAM_BASE_OFFSET;
	assign in_ram = (bus.addr >= soc_io_pkg::RAM_BASE_OFFSET) &&
		(ram_offset < soc_io_pkg::bus_addr_t'(soc_io_pkg::RAM_WORDS * 4));
	assign ram_we = (start && bus.write && in_ram) ? bus.wstrb : '0;

	scratch_ram scratch_ram_inst (
		.clk_50mhz(clk_50mhz),
		.byte_we(ram_we),
		.index(ram_offset[$bits(soc_io_pkg::ram_index_t) + 1:2]),
		.wdata(bus.wdata),
		.rdata(ram_rdata)
	);

	// Pad n in byte n
	always_comb begin
		pads_word = '0;
		for (int n = 0; n < soc_io_pkg::PAD_COUNT; n++) begin
			pads_word[n * soc_io_pkg::PAD_BITS +: soc_io_pkg::PAD_BITS] = pad_buttons[n];
		end
	end

	always_comb begin
		reg_rdata = '0;
		reg_err = 1'b0;
		if (!in_ram) begin
			if (bus.write) begin
				reg_err = 1'b1;
			end else begin
				case (bus.addr)
					soc_io_pkg::REG_ID_OFFSET: reg_rdata = soc_io_pkg::SOC_IO_ID;
					soc_io_pkg::REG_CYCLES_OFFSET: reg_rdata = cycle_count;
					soc_io_pkg::REG_PADS_OFFSET: reg_rdata = pads_word;
					default: reg_err = 1'b1;
				endcase
			end
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			ack_q <= 1'b0;
			cycle_count <= '0;
		end else begin
			ack_q <= start;
			cycle_count <= cycle_count + 1'b1;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (start) begin
			rdata_q <= reg_rdata;
			err_q <= reg_err;
			ram_sel_q <= in_ram;
		end
	end

	// RAM data arrives in the ack cycle
	assign bus.rdata = ram_sel_q ? ram_rdata : rdata_q;
	assign bus.err = err_q;
	assign bus.ack = ack_q;

endmodule

//--- src/scratch_ram.sv
// Word scratch memory with per-byte write enables and registered read data
`timescale 1ns/10ps

module scratch_ram (
	input logic clk_50mhz,
	input soc_io_pkg::bus_strb_t byte_we,
	input soc_io_pkg::ram_index_t index,
	input soc_io_pkg::bus_data_t wdata,
	output soc_io_pkg::bus_data_t rdata
);

	soc_io_pkg::bus_data_t mem [soc_io_pkg::RAM_WORDS];

	always_ff @(posedge clk_50mhz) begin
		for (int lane = 0; lane < $bits(soc_io_pkg::bus_strb_t); lane++) begin
			if (byte_we[lane]) begin
				mem[index][lane * 8 +: 8] <= wdata[lane * 8 +: 8];
			end
		end
	end

	// Old word comes back when the same address is written
	always_ff @(posedge clk_50mhz) begin
		rdata <= mem[index];
	end

endmodule

//--- src/pad_reader.sv
// Collects one pad's serial button bits and publishes the whole byte at the end of each frame
`timescale 1ns/10ps

module pad_reader (
	input logic clk_50mhz,
	input logic resetn,
	pad_seq_if.sink seq,
	input logic pad_data,
	output soc_io_pkg::pad_buttons_t buttons
);

	soc_io_pkg::pad_buttons_t working;

	// Pad line is low while a button is pressed
	always_ff @(posedge clk_50mhz) begin
		if (seq.sample) begin
			working[seq.bit_idx] <= ~pad_data;
		end
	end

	// Software only sees complete frames
	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			buttons <= '0;
		end else if (seq.frame_done) begin
			buttons <= working;
		end
	end

endmodule

//--- src/pad_sequencer.sv
// Divides the clock into pad ticks and steps the latch, clock and sample timing of each frame
`timescale 1ns/10ps

module pad_sequencer (
	input logic clk_50mhz,
	input logic resetn,
	pad_seq_if.source seq
);

	logic [$clog2(soc_io_pkg::PAD_TICK_CYCLES)-1:0] div_cnt;
	logic [$clog2(soc_io_pkg::PAD_FRAME_TICKS)-1:0] frame_cnt;
	logic tick;
	logic sample;
	soc_io_pkg::pad_seq_state_t state;
	soc_io_pkg::pad_bit_idx_t bit_idx;
	logic frame_done;

	assign tick = (div_cnt == soc_io_pkg::PAD_TICK_CYCLES - 1);
	// Last cycle of each clock low phase
	assign sample = (state == soc_io_pkg::clock_low) && tick;

	assign seq.latch = (state == soc_io_pkg::latch);
	assign seq.clock = (state != soc_io_pkg::clock_low);
	assign seq.sample = sample;
	assign seq.bit_idx = bit_idx;
	assign seq.frame_done = frame_done;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			div_cnt <= '0;
			frame_cnt <= '0;
			state <= soc_io_pkg::idle;
			bit_idx <= '0;
			frame_done <= 1'b0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			frame_done <= sample && (bit_idx == soc_io_pkg::PAD_BITS - 1);
			if (tick) begin
				frame_cnt <= (frame_cnt == soc_io_pkg::PAD_FRAME_TICKS - 1) ? '0 : frame_cnt + 1'b1;
				case (state)
					soc_io_pkg::idle: begin
						if (frame_cnt == soc_io_pkg::PAD_FRAME_TICKS - 1) begin
							state <= soc_io_pkg::latch;
						end
					end
					soc_io_pkg::latch: begin
						bit_idx <= '0;
						state <= soc_io_pkg::clock_low;
					end
					soc_io_pkg::clock_low: begin
						state <= soc_io_pkg::clock_high;
					end
					default: begin
						if (bit_idx == soc_io_pkg::PAD_BITS - 1) begin
							state <= soc_io_pkg::idle;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							state <= soc_io_pkg::clock_low;
						end
					end
				endcase
			end
		end
	end

endmodule

//--- src/axil_slave_port.sv
// AXI-Lite slave that turns each bus transaction into one access on the internal register bus
`timescale 1ns/10ps

module axil_slave_port (
	input logic clk_50mhz,
	input logic resetn,

	input soc_io_pkg::bus_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input soc_io_pkg::bus_data_t wdata,
	input soc_io_pkg::bus_strb_t wstrb,
	input logic wvalid,
	output logic wready,
	output soc_io_pkg::bus_resp_t bresp,
	output logic bvalid,
	input logic bready,
	input soc_io_pkg::bus_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output soc_io_pkg::bus_data_t rdata,
	output soc_io_pkg::bus_resp_t rresp,
	output logic rvalid,
	input logic rready,

	reg_bus_if.initiator bus
);

	typedef enum logic [1:0] {
		axil_idle,
		axil_access,
		axil_wr_resp,
		axil_rd_resp
	} axil_state_t;

	axil_state_t state;
	logic write_q;
	soc_io_pkg::bus_addr_t addr_q;
	soc_io_pkg::bus_data_t wdata_q;
	soc_io_pkg::bus_strb_t wstrb_q;
	soc_io_pkg::bus_data_t rdata_q;
	soc_io_pkg::bus_resp_t resp_q;

	// Reads win over writes when both are pending
	assign arready = (state == axil_idle) && arvalid;
	assign awready = (state == axil_idle) && !arvalid && awvalid && wvalid;
	assign wready = awready;

	assign bus.req = (state == axil_access);
	assign bus.write = write_q;
	assign bus.addr = addr_q;
	assign bus.wdata = wdata_q;
	assign bus.wstrb = wstrb_q;

	assign rvalid = (state == axil_rd_resp);
	assign bvalid = (state == axil_wr_resp);
	assign rdata = rdata_q;
	assign rresp = resp_q;
	assign bresp = resp_q;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			state <= axil_idle;
		end else begin
			case (state)
				axil_idle: begin
					if (arready || awready) begin
						state <= axil_access;
					end
				end
				axil_access: begin
					if (bus.ack) begin
						state <= write_q ? axil_wr_resp : axil_rd_resp;
					end
				end
				axil_wr_resp: begin
					if (bready) begin
						state <= axil_idle;
					end
				end
				default: begin
					if (rready) begin
						state <= axil_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (arready) begin
			addr_q <= araddr;
			write_q <= 1'b0;
		end else if (awready) begin
			addr_q <= awaddr;
			wdata_q <= wdata;
			wstrb_q <= wstrb;
			write_q <= 1'b1;
		end
		// Response held until the manager takes it
		if (bus.req && bus.ack) begin
			rdata_q <= bus.rdata;
			resp_q <= bus.err ? soc_io_pkg::RESP_SLVERR : soc_io_pkg::RESP_OKAY;
		end
	end

endmodule

//--- src/pad_seq_if.sv
// Shared pad latch, clock and sample timing from the sequencer to the pad readers
`timescale 1ns/10ps

interface pad_seq_if;

	logic latch;
	logic clock;
	logic sample;
	soc_io_pkg::pad_bit_idx_t bit_idx;
	logic frame_done;

	modport source (output latch, clock, sample, bit_idx, frame_done);

	modport sink (input latch, clock, sample, bit_idx, frame_done);

endinterface

//--- src/reg_bus_if.sv
// Single register access channel from the AXI-Lite port to the register map
`timescale 1ns/10ps

interface reg_bus_if;

	logic req;
	logic write;
	soc_io_pkg::bus_addr_t addr;
	soc_io_pkg::bus_data_t wdata;
	soc_io_pkg::bus_strb_t wstrb;
	soc_io_pkg::bus_data_t rdata;
	logic ack;
	// Unmapped address or write to a read-only register
	logic err;

	modport initiator (output req, write, addr, wdata, wstrb, input rdata, ack, err);

	modport target (input req, write, addr, wdata, wstrb, output rdata, ack, err);

endinterface

//--- src/soc_io_pkg.sv
// Bus types, register offsets and game pad timing shared by every RTL file through scoped names
package soc_io_pkg;

	typedef logic [11:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	typedef logic [3:0] bus_strb_t;
	typedef logic [1:0] bus_resp_t;

	// One bit per button, 1 means pressed
	typedef logic [7:0] pad_buttons_t;
	typedef logic [2:0] pad_bit_idx_t;
	typedef logic [5:0] ram_index_t;

	typedef enum logic [1:0] {
		idle,
		latch,
		clock_low,
		clock_high
	} pad_seq_state_t;

	localparam bus_resp_t RESP_OKAY = 2'd0;
	localparam bus_resp_t RESP_SLVERR = 2'd2;

	localparam bus_data_t SOC_IO_ID = 32'h50AD_0001;

	// Register offsets
	localparam bus_addr_t REG_ID_OFFSET = 12'h000;
	localparam bus_addr_t REG_CYCLES_OFFSET = 12'h004;
	localparam bus_addr_t REG_PADS_OFFSET = 12'h008;
	localparam bus_addr_t RAM_BASE_OFFSET = 12'h100;
	localparam int RAM_WORDS = 64;

	localparam int PAD_COUNT = 2;
	localparam int PAD_BITS = 8;
	// One tick every 512 clocks, 32 ticks per frame
	localparam int PAD_TICK_CYCLES = 512;
	localparam int PAD_FRAME_TICKS = 32;

endpackage
